//--- mapper_settings.svh
`ifndef MAPPER_SETTINGS_SVH
`define MAPPER_SETTINGS_SVH

// --------------------------------------------------
// screen
// --------------------------------------------------
`define SCREEN_W    8
`define SCREEN_H    6

// --------------------------------------------------
// texture
// --------------------------------------------------
`define TEX_BITS    4   // log2 of the texture side, 16x16 texels
`define COMP_NUM    3   // components per texel
`define COMP_BITS   8   // bits per component

// --------------------------------------------------
// fixed point
// --------------------------------------------------
`define FRAC_BITS   4
`define COORD_BITS  16  // signed texture coordinate
`define COEFF_BITS  16  // signed matrix coefficient

`endif

//--- texture_pkg.sv
`include "mapper_settings.svh"

package texture_pkg;

    // one colour channel
    typedef logic [`COMP_BITS-1:0] component_t;

    // whole texel, component 0 in the low bits
    typedef component_t [`COMP_NUM-1:0] texel_t;

    typedef logic [`TEX_BITS-1:0] tex_index_t;  // texel column or row

endpackage

//--- coord_pkg.sv
`include "mapper_settings.svh"

package coord_pkg;

    typedef logic signed [`COEFF_BITS-1:0] coeff_t;  // matrix entry, same scale as coords

    typedef logic [`FRAC_BITS-1:0] frac_t;

    // integer and fraction fields of a coordinate
    typedef struct packed {
        logic signed [`COORD_BITS-`FRAC_BITS-1:0] int_part;
        frac_t                                    frac;
    } coord_split_t;

    // one coordinate word, read as a number or as its two fields
    typedef union packed {
        logic signed [`COORD_BITS-1:0] whole;  // for the affine sums
        coord_split_t                  split;  // for the texel address
    } coord_t;

    typedef logic [$clog2(`SCREEN_W)-1:0] screen_x_t;
    typedef logic [$clog2(`SCREEN_H)-1:0] screen_y_t;

endpackage

//--- raster_scan.sv
`timescale 1ns/1ps
`include "mapper_settings.svh"

module raster_scan (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    output logic                  busy,
    input  logic                  drain,
    output logic                  scan_valid,
    output coord_pkg::screen_x_t  scan_x,
    output coord_pkg::screen_y_t  scan_y
);

    logic armed;      // start taken, first pixel goes out next cycle
    logic scan_done;  // all pixels issued, waiting for the pipeline

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            armed      <= 1'b0;
            scan_done  <= 1'b0;
            scan_valid <= 1'b0;
            scan_x     <= '0;
            scan_y     <= '0;
        end else begin
            armed <= start && !busy;
            if (start && !busy) begin
                busy <= 1'b1;
            end

            if (armed) begin
                scan_valid <= 1'b1;
                scan_x     <= '0;
                scan_y     <= '0;
            end else if (scan_valid) begin
                if (scan_x == coord_pkg::screen_x_t'(`SCREEN_W - 1)) begin
                    scan_x <= '0;
                    if (scan_y == coord_pkg::screen_y_t'(`SCREEN_H - 1)) begin
                        scan_valid <= 1'b0;  // last pixel of the frame
                        scan_done  <= 1'b1;
                    end else begin
                        scan_y <= scan_y + 1'b1;
                    end
                end else begin
                    scan_x <= scan_x + 1'b1;
                end
            end

            if (scan_done && drain) begin
                busy      <= 1'b0;
                scan_done <= 1'b0;
            end
        end
    end

endmodule

//--- affine_transform.sv
`timescale 1ns/1ps
`include "mapper_settings.svh"

module affine_transform (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  coord_pkg::screen_x_t  in_x,
    input  coord_pkg::screen_y_t  in_y,
    input  coord_pkg::coeff_t     m00,
    input  coord_pkg::coeff_t     m01,
    input  coord_pkg::coeff_t     m02,
    input  coord_pkg::coeff_t     m10,
    input  coord_pkg::coeff_t     m11,
    input  coord_pkg::coeff_t     m12,
    output logic                  out_valid,
    output coord_pkg::coord_t     out_u,
    output coord_pkg::coord_t     out_v
);

    logic signed [`COORD_BITS-1:0] sx;
    logic signed [`COORD_BITS-1:0] sy;

    logic                          prod_valid;
    logic signed [`COORD_BITS-1:0] p00;
    logic signed [`COORD_BITS-1:0] p01;
    logic signed [`COORD_BITS-1:0] p10;
    logic signed [`COORD_BITS-1:0] p11;

    // screen position as a non-negative signed integer
    assign sx = `COORD_BITS'(in_x);
    assign sy = `COORD_BITS'(in_y);

    // --------------------------------------------------
    // stage 1: products
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        p00 <= m00 * sx;  // integer times coeff keeps the coeff scale
        p01 <= m01 * sy;
        p10 <= m10 * sx;
        p11 <= m11 * sy;
    end

    // --------------------------------------------------
    // stage 2: sums with offsets, wrap to 16 bits
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        out_u.whole <= p00 + p01 + m02;
        out_v.whole <= p10 + p11 + m12;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prod_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            prod_valid <= in_valid;
            out_valid  <= prod_valid;
        end
    end

endmodule

//--- texel_fetch.sv
`timescale 1ns/1ps
`include "mapper_settings.svh"

module texel_fetch (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  coord_pkg::coord_t        in_u,
    input  coord_pkg::coord_t        in_v,
    input  logic                     tex_wr_en,
    input  texture_pkg::tex_index_t  tex_wr_x,
    input  texture_pkg::tex_index_t  tex_wr_y,
    input  texture_pkg::texel_t      tex_wr_data,
    output logic                     out_valid,
    output logic                     out_border,
    output coord_pkg::frac_t         out_fx,
    output coord_pkg::frac_t         out_fy,
    output texture_pkg::texel_t      out_t00,
    output texture_pkg::texel_t      out_t01,
    output texture_pkg::texel_t      out_t10,
    output texture_pkg::texel_t      out_t11
);

    localparam int TEX_LAST   = (1 << `TEX_BITS) - 2;  // last index with a right/lower neighbour
    localparam int BANK_ABITS = 2 * (`TEX_BITS - 1);

    texture_pkg::tex_index_t ix, iy, ix1, iy1;
    logic                    border;
    logic [1:0]              wr_bank;
    logic [BANK_ABITS-1:0]   wr_addr;

    logic                    s1_valid, s1_border, s1_sx, s1_sy;
    coord_pkg::frac_t        s1_fx, s1_fy;
    logic [BANK_ABITS-1:0]   rd_addr [4];

    logic                    s2_sx, s2_sy;
    texture_pkg::texel_t     rd_q [4];

    assign ix  = in_u.split.int_part[`TEX_BITS-1:0];
    assign iy  = in_v.split.int_part[`TEX_BITS-1:0];
    assign ix1 = ix + 1'b1;
    assign iy1 = iy + 1'b1;

    assign border = (int'(in_u.split.int_part) < 0) || (int'(in_u.split.int_part) > TEX_LAST)
                 || (int'(in_v.split.int_part) < 0) || (int'(in_v.split.int_part) > TEX_LAST);

    // bank is picked by {y parity, x parity}
    assign wr_bank = {tex_wr_y[0], tex_wr_x[0]};
    assign wr_addr = {tex_wr_y[`TEX_BITS-1:1], tex_wr_x[`TEX_BITS-1:1]};

    // --------------------------------------------------
    // four banks, each neighbour lands in its own bank
    // --------------------------------------------------
    for (genvar b = 0; b < 4; b++) begin : g_bank
        localparam int PX = b % 2;
        localparam int PY = b / 2;

        texture_pkg::texel_t     mem [1 << BANK_ABITS];
        texture_pkg::tex_index_t bx, by;

        assign bx = (ix[0] == 1'(PX)) ? ix : ix1;
        assign by = (iy[0] == 1'(PY)) ? iy : iy1;

        always_ff @(posedge clk) begin
            rd_addr[b] <= {by[`TEX_BITS-1:1], bx[`TEX_BITS-1:1]};  // stage 1
        end

        always_ff @(posedge clk) begin
            if (tex_wr_en && wr_bank == 2'(b)) begin
                mem[wr_addr] <= tex_wr_data;
            end
            rd_q[b] <= mem[rd_addr[b]];  // stage 2
        end
    end

    always_ff @(posedge clk) begin
        s1_border  <= border;
        s1_fx      <= in_u.split.frac;
        s1_fy      <= in_v.split.frac;
        s1_sx      <= ix[0];
        s1_sy      <= iy[0];
        out_border <= s1_border;
        out_fx     <= s1_fx;
        out_fy     <= s1_fy;
        s2_sx      <= s1_sx;
        s2_sy      <= s1_sy;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
        end
    end

    // back from bank order to neighbour position
    assign out_t00 = rd_q[{s2_sy, s2_sx}];
    assign out_t01 = rd_q[{s2_sy, ~s2_sx}];
    assign out_t10 = rd_q[{~s2_sy, s2_sx}];
    assign out_t11 = rd_q[{~s2_sy, ~s2_sx}];

endmodule

//--- bilinear_blend.sv
`timescale 1ns/1ps
`include "mapper_settings.svh"

module bilinear_blend (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  logic                 in_border,
    input  coord_pkg::frac_t     in_fx,
    input  coord_pkg::frac_t     in_fy,
    input  texture_pkg::texel_t  in_t00,
    input  texture_pkg::texel_t  in_t01,
    input  texture_pkg::texel_t  in_t10,
    input  texture_pkg::texel_t  in_t11,
    input  logic                 nearest,
    input  texture_pkg::texel_t  border_value,
    output logic                 out_valid,
    output logic                 out_border,
    output texture_pkg::texel_t  out_texel
);

    localparam int HSUM_BITS = `COMP_BITS + `FRAC_BITS;
    localparam int VSUM_BITS = `COMP_BITS + 2 * `FRAC_BITS;
    localparam logic [`FRAC_BITS:0] ONE = 1 << `FRAC_BITS;

    logic [`FRAC_BITS:0]  wx0, wx1, wy0, wy1;
    logic [HSUM_BITS-1:0] h_top [`COMP_NUM];
    logic [HSUM_BITS-1:0] h_bot [`COMP_NUM];
    logic [VSUM_BITS-1:0] v_sum [`COMP_NUM];
    logic                 s1_valid, s1_border;
    coord_pkg::frac_t     s1_fy;
    texture_pkg::texel_t  s1_t00;
    texture_pkg::texel_t  blend_texel;

    assign wx1 = {1'b0, in_fx};
    assign wx0 = ONE - wx1;
    assign wy1 = {1'b0, s1_fy};
    assign wy0 = ONE - wy1;

    // --------------------------------------------------
    // stage 1: horizontal weighting per row
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        for (int c = 0; c < `COMP_NUM; c++) begin
            h_top[c] <= in_t00[c] * wx0 + in_t01[c] * wx1;
            h_bot[c] <= in_t10[c] * wx0 + in_t11[c] * wx1;
        end
        s1_t00    <= in_t00;  // kept for nearest mode
        s1_fy     <= in_fy;
        s1_border <= in_border;
    end

    // --------------------------------------------------
    // stage 2: vertical weighting and output select
    // --------------------------------------------------
    always_comb begin
        for (int c = 0; c < `COMP_NUM; c++) begin
            v_sum[c]       = h_top[c] * wy0 + h_bot[c] * wy1;
            blend_texel[c] = v_sum[c][VSUM_BITS-1 -: `COMP_BITS];  // >> 8, truncating
        end
    end

    always_ff @(posedge clk) begin
        if (s1_border) begin
            out_texel <= border_value;
        end else if (nearest) begin
            out_texel <= s1_t00;
        end else begin
            out_texel <= blend_texel;
        end
        out_border <= s1_border;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
        end
    end

endmodule

//--- texture_mapper.sv
`timescale 1ns/1ps

module texture_mapper (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    output logic                     busy,
    input  coord_pkg::coeff_t        m00,
    input  coord_pkg::coeff_t        m01,
    input  coord_pkg::coeff_t        m02,
    input  coord_pkg::coeff_t        m10,
    input  coord_pkg::coeff_t        m11,
    input  coord_pkg::coeff_t        m12,
    input  logic                     nearest,
    input  texture_pkg::texel_t      border_value,
    input  logic                     tex_wr_en,
    input  texture_pkg::tex_index_t  tex_wr_x,
    input  texture_pkg::tex_index_t  tex_wr_y,
    input  texture_pkg::texel_t      tex_wr_data,
    output logic                     out_valid,
    output logic                     out_border,
    output texture_pkg::texel_t      out_texel
);

    logic                  drain;
    logic                  scan_valid;
    coord_pkg::screen_x_t  scan_x;
    coord_pkg::screen_y_t  scan_y;

    logic                  aff_valid;
    coord_pkg::coord_t     aff_u, aff_v;

    logic                  fetch_valid, fetch_border;
    coord_pkg::frac_t      fetch_fx, fetch_fy;
    texture_pkg::texel_t   fetch_t00, fetch_t01, fetch_t10, fetch_t11;

    // samples run back to back, so one valid per stage pair is enough to see the train
    assign drain = !(scan_valid || aff_valid || fetch_valid || out_valid);

    raster_scan u_scan (
        .clk(clk), .reset(reset), .start(start), .busy(busy), .drain(drain),
        .scan_valid(scan_valid), .scan_x(scan_x), .scan_y(scan_y)
    );

    affine_transform u_affine (
        .clk(clk), .reset(reset), .in_valid(scan_valid), .in_x(scan_x), .in_y(scan_y),
        .m00(m00), .m01(m01), .m02(m02), .m10(m10), .m11(m11), .m12(m12),
        .out_valid(aff_valid), .out_u(aff_u), .out_v(aff_v)
    );

    texel_fetch u_fetch (
        .clk(clk), .reset(reset), .in_valid(aff_valid), .in_u(aff_u), .in_v(aff_v),
        .tex_wr_en(tex_wr_en), .tex_wr_x(tex_wr_x), .tex_wr_y(tex_wr_y),
        .tex_wr_data(tex_wr_data),
        .out_valid(fetch_valid), .out_border(fetch_border),
        .out_fx(fetch_fx), .out_fy(fetch_fy),
        .out_t00(fetch_t00), .out_t01(fetch_t01), .out_t10(fetch_t10), .out_t11(fetch_t11)
    );

    bilinear_blend u_blend (
        .clk(clk), .reset(reset), .in_valid(fetch_valid), .in_border(fetch_border),
        .in_fx(fetch_fx), .in_fy(fetch_fy),
        .in_t00(fetch_t00), .in_t01(fetch_t01), .in_t10(fetch_t10), .in_t11(fetch_t11),
        .nearest(nearest), .border_value(border_value),
        .out_valid(out_valid), .out_border(out_border), .out_texel(out_texel)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

//--- texture_mapper_checker.sv
`timescale 1ns/1ps

module texture_mapper_checker (
    input logic                 clk,
    input logic                 reset,
    input logic                 busy,
    input logic                 out_valid,
    input logic                 out_border,
    input texture_pkg::texel_t  out_texel,
    input texture_pkg::texel_t  border_value
);

    // outputs only appear inside a frame
    a_valid_in_frame: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> busy)
        else $error("out_valid high while busy is low");

    a_border_colour: assert property (@(posedge clk) disable iff (reset)
        (out_valid && out_border) |-> (out_texel == border_value))
        else $error("border sample does not carry border_value");

    // sync reset leaves the mapper idle
    a_reset_idle: assert property (@(posedge clk)
        reset |=> (!busy && !out_valid))
        else $error("busy or out_valid high right after reset");

endmodule

bind texture_mapper texture_mapper_checker u_checker (
    .clk          (clk),
    .reset        (reset),
    .busy         (busy),
    .out_valid    (out_valid),
    .out_border   (out_border),
    .out_texel    (out_texel),
    .border_value (border_value)
);

//--- tb_texture_mapper.sv
`timescale 1ns/1ps
`include "mapper_settings.svh"

module tb_texture_mapper;

    localparam int MAX_CASES  = 16;
    localparam int CASE_WORDS = 8;  // six coefficients, nearest, border colour
    localparam int TEX_SIDE   = 1 << `TEX_BITS;
    localparam int PIXELS     = `SCREEN_W * `SCREEN_H;
    localparam int LATENCY    = 7;
    localparam int ONE        = 1 << `FRAC_BITS;

    logic                    clk;
    logic                    reset;
    logic                    start;
    logic                    busy;
    coord_pkg::coeff_t       m00, m01, m02, m10, m11, m12;
    logic                    nearest;
    texture_pkg::texel_t     border_value;
    logic                    tex_wr_en;
    texture_pkg::tex_index_t tex_wr_x, tex_wr_y;
    texture_pkg::texel_t     tex_wr_data;
    logic                    out_valid;
    logic                    out_border;
    texture_pkg::texel_t     out_texel;

    logic [23:0]         case_mem [MAX_CASES*CASE_WORDS];
    texture_pkg::texel_t tex_model [TEX_SIDE][TEX_SIDE];  // [y][x]
    logic [31:0]         rng_state;
    int                  n_cases;
    int                  cur_case;
    int                  cycle_count = 0;
    int                  cycle_limit = 1000000;

    tb_clock_gen #(.PERIOD_NS(40)) u_clk (.clk(clk));

    texture_mapper u_dut (
        .clk(clk), .reset(reset), .start(start), .busy(busy),
        .m00(m00), .m01(m01), .m02(m02), .m10(m10), .m11(m11), .m12(m12),
        .nearest(nearest), .border_value(border_value),
        .tex_wr_en(tex_wr_en), .tex_wr_x(tex_wr_x), .tex_wr_y(tex_wr_y),
        .tex_wr_data(tex_wr_data),
        .out_valid(out_valid), .out_border(out_border), .out_texel(out_texel)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_texel(input string name, input texture_pkg::texel_t got,
                               input texture_pkg::texel_t exp, input int pixel);
        if (got !== exp) begin
            abort_run($sformatf("error %s = 0x%06h, expected 0x%06h (case %0d, pixel %0d)",
                                name, got, exp, cur_case, pixel));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp,
                              input int pixel);
        if (got !== exp) begin
            abort_run($sformatf("error %s = 0x%0h, expected 0x%0h (case %0d, pixel %0d)",
                                name, got, exp, cur_case, pixel));
        end
    endtask

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic void expected_sample(input int x, input int y,
                                            output texture_pkg::texel_t texel,
                                            output logic border);
        int                  u, v, iu, iv, fx, fy, top, bot;
        logic signed [`COORD_BITS-1:0] u16, v16;
        texture_pkg::texel_t t00, t01, t10, t11;
        u   = int'(m00) * x + int'(m01) * y + int'(m02);
        v   = int'(m10) * x + int'(m11) * y + int'(m12);
        u16 = u[`COORD_BITS-1:0];  // wraps like a 16-bit sum
        v16 = v[`COORD_BITS-1:0];
        iu  = int'(u16) >>> `FRAC_BITS;
        iv  = int'(v16) >>> `FRAC_BITS;
        fx  = int'(u16[`FRAC_BITS-1:0]);
        fy  = int'(v16[`FRAC_BITS-1:0]);
        border = (iu < 0) || (iu > TEX_SIDE - 2) || (iv < 0) || (iv > TEX_SIDE - 2);
        if (border) begin
            texel = border_value;
        end else if (nearest) begin
            texel = tex_model[iv][iu];
        end else begin
            t00 = tex_model[iv][iu];
            t01 = tex_model[iv][iu+1];
            t10 = tex_model[iv+1][iu];
            t11 = tex_model[iv+1][iu+1];
            for (int c = 0; c < `COMP_NUM; c++) begin
                top      = int'(t00[c]) * (ONE - fx) + int'(t01[c]) * fx;
                bot      = int'(t10[c]) * (ONE - fx) + int'(t11[c]) * fx;
                texel[c] = texture_pkg::component_t'(
                               (top * (ONE - fy) + bot * fy) >> (2 * `FRAC_BITS));
            end
        end
    endfunction

    task automatic load_texture();
        for (int y = 0; y < TEX_SIDE; y++) begin
            for (int x = 0; x < TEX_SIDE; x++) begin
                rng_state = xorshift32(rng_state);
                @(negedge clk);
                tex_wr_en       = 1'b1;
                tex_wr_x        = texture_pkg::tex_index_t'(x);
                tex_wr_y        = texture_pkg::tex_index_t'(y);
                tex_wr_data     = rng_state[23:0];
                tex_model[y][x] = rng_state[23:0];
            end
        end
        @(negedge clk);
        tex_wr_en = 1'b0;
    endtask

    task automatic run_case(input int k);
        int                  base;
        int                  wait_n;
        texture_pkg::texel_t exp_texel;
        logic                exp_border;
        base     = k * CASE_WORDS;
        cur_case = k;
        load_texture();
        m00          = case_mem[base][15:0];
        m01          = case_mem[base+1][15:0];
        m02          = case_mem[base+2][15:0];
        m10          = case_mem[base+3][15:0];
        m11          = case_mem[base+4][15:0];
        m12          = case_mem[base+5][15:0];
        nearest      = case_mem[base+6][0];
        border_value = case_mem[base+7];
        if (busy !== 1'b0) begin
            abort_run($sformatf("busy is high before start in case %0d", k));
        end
        start = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        wait_n = 0;
        while (out_valid !== 1'b1) begin
            if (wait_n == LATENCY) begin
                abort_run($sformatf("no output %0d cycles after start in case %0d", LATENCY, k));
            end
            @(negedge clk);
            wait_n++;
        end
        if (wait_n != LATENCY) begin
            abort_run($sformatf("first output came %0d cycles after start, not %0d",
                                wait_n, LATENCY));
        end
        for (int i = 0; i < PIXELS; i++) begin
            if (out_valid !== 1'b1) begin
                abort_run($sformatf("output stream broke off at pixel %0d of case %0d", i, k));
            end
            if (busy !== 1'b1) begin
                abort_run($sformatf("busy fell during the output of case %0d", k));
            end
            expected_sample(i % `SCREEN_W, i / `SCREEN_W, exp_texel, exp_border);
            check_flag("out_border", out_border, exp_border, i);
            check_texel("out_texel", out_texel, exp_texel, i);
            start = (i == PIXELS / 2);  // start while busy is ignored
            @(negedge clk);
        end
        if (out_valid !== 1'b0) begin
            abort_run($sformatf("more than %0d outputs in case %0d", PIXELS, k));
        end
        if (busy !== 1'b1) begin
            abort_run($sformatf("busy fell before the pipeline drained in case %0d", k));
        end
        wait_n = 0;
        while (busy !== 1'b0) begin
            if (wait_n == 4) begin
                abort_run($sformatf("busy stuck high after case %0d", k));
            end
            @(negedge clk);
            wait_n++;
        end
        repeat (3) begin
            @(negedge clk);
            if (out_valid !== 1'b0 || busy !== 1'b0) begin
                abort_run($sformatf("a start given while busy began a new frame in case %0d", k));
            end
        end
    endtask

    // --------------------------------------------------
    // run limit and protocol watch
    // --------------------------------------------------
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            abort_run($sformatf("timeout, the run went past %0d cycles", cycle_limit));
        end
    end

    always @(negedge clk) begin
        if (!reset && out_valid === 1'b1 && busy !== 1'b1) begin
            abort_run("an output appeared while busy was low");
        end
    end

    initial begin
        reset        = 1'b1;
        start        = 1'b0;
        m00          = '0;
        m01          = '0;
        m02          = '0;
        m10          = '0;
        m11          = '0;
        m12          = '0;
        nearest      = 1'b0;
        border_value = '0;
        tex_wr_en    = 1'b0;
        tex_wr_x     = '0;
        tex_wr_y     = '0;
        tex_wr_data  = '0;
        rng_state    = 32'd36019;
        $readmemh("mapper_input.txt", case_mem);
        n_cases = 0;
        while (n_cases < MAX_CASES
               && !$isunknown(case_mem[n_cases*CASE_WORDS + CASE_WORDS - 1])) begin
            n_cases++;
        end
        if (n_cases == 0) begin
            abort_run("no test cases found in mapper_input.txt");
        end
        cycle_limit = 2 * n_cases * (TEX_SIDE * TEX_SIDE + PIXELS + 10);
        repeat (2) @(negedge clk);
        reset = 1'b0;
        for (int k = 0; k < n_cases; k++) begin
            run_case(k);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- mapper_input.txt
// columns: m00 m01 m02 m10 m11 m12 as 16-bit signed hex with 4 fraction bits,
//          then nearest (0 bilinear, 1 nearest), then border colour (24-bit hex)

// identity, bilinear
0010 0000 0000 0000 0010 0000 0 102030

// rotation near 45 degrees, half-texel offset, bilinear
000b 000b 0008 fff5 000b 0068 0 204060

// same matrix, nearest
000b 000b 0008 fff5 000b 0068 1 204060

// shifted 3 left and 10 down, edge samples leave the texture
0010 0000 ffd0 0000 0010 00a0 0 ff00ff

// scaled and skewed, first samples just below zero
0018 0004 fff8 fffc 0014 0024 0 00ff00

// scale 2, nearest, reaches texel 14 on the right
0020 0000 0000 0000 0020 0000 1 abcdef

// large scale, u wraps in 16 bits back into the texture at x = 4
4000 0000 0018 0000 0010 0008 0 5a5a5a

//--- tb.f
+incdir+.
texture_pkg.sv
coord_pkg.sv
raster_scan.sv
affine_transform.sv
texel_fetch.sv
bilinear_blend.sv
texture_mapper.sv
tb_clock_gen.sv
texture_mapper_checker.sv
tb_texture_mapper.sv

//--- Bender.yml
package:
  name: texture_mapper

sources:
  - include_dirs:
      - .
    files:
      - texture_pkg.sv
      - coord_pkg.sv
      - raster_scan.sv
      - affine_transform.sv
      - texel_fetch.sv
      - bilinear_blend.sv
      - texture_mapper.sv
      - target: test
        files:
          - tb_clock_gen.sv
          - texture_mapper_checker.sv
          - tb_texture_mapper.sv
